//--- include/plic_map.svh
`ifndef PLIC_MAP_SVH
`define PLIC_MAP_SVH

// Source priorities, one word per source, offset 0 is reserved
`define PLIC_PRIO_BASE   24'h000000

// Pending bits, bit s is source s
`define PLIC_PENDING     24'h001000

// Per-target enable masks
`define PLIC_IE_BASE     24'h002000
`define PLIC_IE_STRIDE   24'h000080

// Per-target threshold, claim/complete sits one word above it
`define PLIC_TH_BASE     24'h200000
`define PLIC_TH_STRIDE   24'h001000
`define PLIC_CLAIM_OFS   24'h000004

`endif

//--- rtl/plic_pkg.sv
package plic_pkg;

    // Data bus width
    localparam int XLEN = 32;

    // Address bits decoded inside the PLIC window
    localparam int REG_OFFSET_WIDTH = 24;

    // ----------------------------------------
    // Data bus request and response
    // ----------------------------------------

    // Request from the bus master, held until ack is seen
    typedef struct packed {
        logic            req;
        logic            w_en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] w_data;
    } plic_bus_req_s;

    // Response, ack is a one-cycle pulse with read data alongside
    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] r_data;
    } plic_bus_rsp_s;

endpackage

//--- rtl/plic_bus_if.sv
interface plic_bus_if
    import plic_pkg::*;
();

    // Request side, driven by the master
    plic_bus_req_s req;

    // Response side, driven by the register block
    plic_bus_rsp_s rsp;

    modport master (
        output req,
        input  rsp
    );

    modport slave (
        input  req,
        output rsp
    );

endinterface

//--- rtl/plic_claim_if.sv
interface plic_claim_if #(
    parameter int SOURCE_COUNT = 4,
    parameter int TARGET_COUNT = 2
) ();

    localparam int SRC_W = $clog2(SOURCE_COUNT) + 1;

    // One lane per target
    logic [TARGET_COUNT-1:0]            claim_strb;
    logic [TARGET_COUNT-1:0]            complete_strb;
    logic [TARGET_COUNT-1:0][SRC_W-1:0] complete_idx;
    logic [TARGET_COUNT-1:0][SRC_W-1:0] claim_idx;

    modport regs (
        output claim_strb,
        output complete_strb,
        output complete_idx,
        input  claim_idx
    );

    modport gateway (
        input  claim_strb,
        input  complete_strb,
        input  complete_idx,
        input  claim_idx
    );

    // Selector only produces the winning index
    modport target (
        output claim_idx
    );

endinterface

//--- rtl/plic_regs.sv
`include "plic_map.svh"

module plic_regs
    import plic_pkg::*;
#(
    parameter int SOURCE_COUNT = 4,
    parameter int TARGET_COUNT = 2,
    parameter int PRIO_WIDTH   = 3
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    plic_bus_if.slave                                bus,
    plic_claim_if.regs                               claim,
    input  logic [SOURCE_COUNT-1:0]                  pending_i,
    output logic [SOURCE_COUNT-1:0][PRIO_WIDTH-1:0]  prio_o,
    output logic [TARGET_COUNT-1:0][SOURCE_COUNT-1:0] ie_o,
    output logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0]  threshold_o
);

    localparam int SRC_W = $clog2(SOURCE_COUNT) + 1;

    logic [REG_OFFSET_WIDTH-1:0] reg_addr;
    logic [XLEN-1:0]             w_data;
    logic                        rd_acc;
    logic                        wr_acc;

    logic [SOURCE_COUNT-1:0] prio_wr;
    logic [TARGET_COUNT-1:0] ie_wr;
    logic [TARGET_COUNT-1:0] th_wr;
    logic [TARGET_COUNT-1:0] claim_rd;
    logic [TARGET_COUNT-1:0] complete_wr;

    logic [SOURCE_COUNT-1:0][PRIO_WIDTH-1:0]   prio_q;
    logic [TARGET_COUNT-1:0][SOURCE_COUNT-1:0] ie_q;
    logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0]   th_q;

    logic            ack_q;
    logic [XLEN-1:0] r_data_d;
    logic [XLEN-1:0] r_data_q;

    // Register addresses with source numbers starting at 1
    function automatic logic [REG_OFFSET_WIDTH-1:0] prio_addr(input int s);
        return REG_OFFSET_WIDTH'(`PLIC_PRIO_BASE + 4 * s);
    endfunction

    function automatic logic [REG_OFFSET_WIDTH-1:0] ie_addr(input int t);
        return REG_OFFSET_WIDTH'(`PLIC_IE_BASE + t * `PLIC_IE_STRIDE);
    endfunction

    function automatic logic [REG_OFFSET_WIDTH-1:0] th_addr(input int t);
        return REG_OFFSET_WIDTH'(`PLIC_TH_BASE + t * `PLIC_TH_STRIDE);
    endfunction

    // A new request is only taken when no ack is outstanding
    assign reg_addr = bus.req.addr[REG_OFFSET_WIDTH-1:0];
    assign w_data   = bus.req.w_data;
    assign rd_acc   = bus.req.req & ~bus.req.w_en & ~ack_q;
    assign wr_acc   = bus.req.req & bus.req.w_en & ~ack_q;

    // ----------------------------------------
    // Read mux and claim decode
    // ----------------------------------------
    always_comb begin
        r_data_d = '0;
        claim_rd = '0;
        if (reg_addr == `PLIC_PENDING) begin
            r_data_d[SOURCE_COUNT:0] = {pending_i, 1'b0};
        end
        for (int s = 0; s < SOURCE_COUNT; s++) begin
            if (reg_addr == prio_addr(s + 1)) begin
                r_data_d[PRIO_WIDTH-1:0] = prio_q[s];
            end
        end
        for (int t = 0; t < TARGET_COUNT; t++) begin
            if (reg_addr == ie_addr(t)) begin
                r_data_d[SOURCE_COUNT:0] = {ie_q[t], 1'b0};
            end
            if (reg_addr == th_addr(t)) begin
                r_data_d[PRIO_WIDTH-1:0] = th_q[t];
            end
            if (reg_addr == th_addr(t) + `PLIC_CLAIM_OFS) begin
                r_data_d[SRC_W-1:0] = claim.claim_idx[t];
                claim_rd[t]         = rd_acc;
            end
        end
    end

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    always_comb begin
        prio_wr     = '0;
        ie_wr       = '0;
        th_wr       = '0;
        complete_wr = '0;
        if (wr_acc) begin
            // Offset 0 and the pending word are not writable
            for (int s = 0; s < SOURCE_COUNT; s++) begin
                prio_wr[s] = (reg_addr == prio_addr(s + 1));
            end
            for (int t = 0; t < TARGET_COUNT; t++) begin
                ie_wr[t]       = (reg_addr == ie_addr(t));
                th_wr[t]       = (reg_addr == th_addr(t));
                complete_wr[t] = (reg_addr == th_addr(t) + `PLIC_CLAIM_OFS);
            end
        end
    end

    // Configuration registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_q <= '0;
            ie_q   <= '0;
            th_q   <= '0;
        end else begin
            for (int s = 0; s < SOURCE_COUNT; s++) begin
                if (prio_wr[s]) begin
                    prio_q[s] <= w_data[PRIO_WIDTH-1:0];
                end
            end
            for (int t = 0; t < TARGET_COUNT; t++) begin
                // Bit 0 of the mask has no source behind it
                if (ie_wr[t]) begin
                    ie_q[t] <= w_data[SOURCE_COUNT:1];
                end
                if (th_wr[t]) begin
                    th_q[t] <= w_data[PRIO_WIDTH-1:0];
                end
            end
        end
    end

    // ----------------------------------------
    // Bus response
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            r_data_q <= '0;
        end else begin
            ack_q <= rd_acc | wr_acc;
            if (rd_acc) begin
                r_data_q <= r_data_d;
            end
        end
    end

    assign bus.rsp = '{ack: ack_q, r_data: r_data_q};

    // Strobes towards the gateways with the index taken straight from write data
    assign claim.claim_strb    = claim_rd;
    assign claim.complete_strb = complete_wr;
    always_comb begin
        for (int t = 0; t < TARGET_COUNT; t++) begin
            claim.complete_idx[t] = w_data[SRC_W-1:0];
        end
    end

    assign prio_o      = prio_q;
    assign ie_o        = ie_q;
    assign threshold_o = th_q;

endmodule

//--- rtl/plic_gateway.sv
module plic_gateway #(
    parameter int SOURCE_COUNT = 4,
    parameter int TARGET_COUNT = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [SOURCE_COUNT-1:0] irq_src_i,
    plic_claim_if.gateway           claim,
    output logic [SOURCE_COUNT-1:0] pending_o
);

    localparam int SRC_W = $clog2(SOURCE_COUNT) + 1;

    logic [SOURCE_COUNT-1:0] pending_q;
    logic [SOURCE_COUNT-1:0] inflight_q;
    logic [SOURCE_COUNT-1:0] claim_hit;
    logic [SOURCE_COUNT-1:0] complete_hit;

    // ----------------------------------------
    // Match strobes against source numbers
    // ----------------------------------------
    // Array slot s holds source s+1, so index 0 never matches
    always_comb begin
        claim_hit    = '0;
        complete_hit = '0;
        for (int s = 0; s < SOURCE_COUNT; s++) begin
            for (int t = 0; t < TARGET_COUNT; t++) begin
                if (claim.claim_strb[t] && claim.claim_idx[t] == SRC_W'(s + 1)) begin
                    claim_hit[s] = 1'b1;
                end
                if (claim.complete_strb[t] && claim.complete_idx[t] == SRC_W'(s + 1)) begin
                    complete_hit[s] = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Per-source request state
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q  <= '0;
            inflight_q <= '0;
        end else begin
            for (int s = 0; s < SOURCE_COUNT; s++) begin
                if (claim_hit[s]) begin
                    // Handed to a target, hold off further requests
                    pending_q[s]  <= 1'b0;
                    inflight_q[s] <= 1'b1;
                end else begin
                    // Completion of an idle source is dropped
                    if (complete_hit[s] && inflight_q[s]) begin
                        inflight_q[s] <= 1'b0;
                    end
                    // Level line only latched while the source is idle
                    if (irq_src_i[s] && !pending_q[s] && !inflight_q[s]) begin
                        pending_q[s] <= 1'b1;
                    end
                end
            end
        end
    end

    assign pending_o = pending_q;

endmodule

//--- rtl/plic_target.sv
module plic_target #(
    parameter int SOURCE_COUNT = 4,
    parameter int TARGET_COUNT = 2,
    parameter int PRIO_WIDTH   = 3
) (
    input  logic [SOURCE_COUNT-1:0]                   pending_i,
    input  logic [TARGET_COUNT-1:0][SOURCE_COUNT-1:0] ie_i,
    input  logic [SOURCE_COUNT-1:0][PRIO_WIDTH-1:0]   prio_i,
    input  logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0]   threshold_i,
    plic_claim_if.target                              claim,
    output logic [TARGET_COUNT-1:0]                   irq_o
);

    localparam int SRC_W = $clog2(SOURCE_COUNT) + 1;

    logic [TARGET_COUNT-1:0][SRC_W-1:0] sel_idx;

    // ----------------------------------------
    // Highest priority eligible source
    // ----------------------------------------
    // The running best starts at the threshold, so only sources strictly
    // above it can win, and priority 0 never does
    function automatic logic [SRC_W-1:0] pick_source(
        input logic [SOURCE_COUNT-1:0]                 eligible,
        input logic [SOURCE_COUNT-1:0][PRIO_WIDTH-1:0] prio,
        input logic [PRIO_WIDTH-1:0]                   threshold
    );
        logic [PRIO_WIDTH-1:0] best_prio;
        logic [SRC_W-1:0]      best_idx;
        best_prio = threshold;
        best_idx  = '0;
        // Ascending scan with strict compare, ties keep the lower number
        for (int s = 0; s < SOURCE_COUNT; s++) begin
            if (eligible[s] && prio[s] > best_prio) begin
                best_prio = prio[s];
                best_idx  = SRC_W'(s + 1);
            end
        end
        return best_idx;
    endfunction

    // One selector per target, all combinational
    always_comb begin
        for (int t = 0; t < TARGET_COUNT; t++) begin
            sel_idx[t] = pick_source(pending_i & ie_i[t], prio_i, threshold_i[t]);
            irq_o[t]   = |sel_idx[t];
        end
    end

    assign claim.claim_idx = sel_idx;

endmodule

//--- rtl/plic_top.sv
module plic_top
    import plic_pkg::*;
#(
    parameter int SOURCE_COUNT = 4,
    parameter int TARGET_COUNT = 2,
    parameter int PRIO_WIDTH   = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  plic_bus_req_s           bus_req_i,
    output plic_bus_rsp_s           bus_rsp_o,
    input  logic [SOURCE_COUNT-1:0] irq_src_i,
    output logic [TARGET_COUNT-1:0] irq_o
);

    logic [SOURCE_COUNT-1:0]                   pending;
    logic [SOURCE_COUNT-1:0][PRIO_WIDTH-1:0]   prio;
    logic [TARGET_COUNT-1:0][SOURCE_COUNT-1:0] ie;
    logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0]   threshold;

    plic_bus_if bus_if ();

    plic_claim_if #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT)
    ) claim_if ();

    // Device select is already part of req at this level
    assign bus_if.req = bus_req_i;
    assign bus_rsp_o  = bus_if.rsp;

    // ----------------------------------------
    // Blocks
    // ----------------------------------------
    plic_regs #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT),
        .PRIO_WIDTH   (PRIO_WIDTH)
    ) u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus_if.slave),
        .claim       (claim_if.regs),
        .pending_i   (pending),
        .prio_o      (prio),
        .ie_o        (ie),
        .threshold_o (threshold)
    );

    plic_gateway #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT)
    ) u_gateway (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_src_i (irq_src_i),
        .claim     (claim_if.gateway),
        .pending_o (pending)
    );

    plic_target #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT),
        .PRIO_WIDTH   (PRIO_WIDTH)
    ) u_target (
        .pending_i   (pending),
        .ie_i        (ie),
        .prio_i      (prio),
        .threshold_i (threshold),
        .claim       (claim_if.target),
        .irq_o       (irq_o)
    );

endmodule

//--- test/plic_tb.sv
`include "plic_map.svh"

module plic_tb
    import plic_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SOURCE_COUNT = 4;
    localparam int TARGET_COUNT = 2;
    localparam int PRIO_WIDTH   = 3;
    localparam int TIMEOUT      = 20;

    localparam logic [XLEN-1:0] PENDING_ADDR = XLEN'(`PLIC_PENDING);
    localparam logic [XLEN-1:0] ALL_SRC      = XLEN'({{SOURCE_COUNT{1'b1}}, 1'b0});

    logic                    clk;
    logic                    rst_n;
    plic_bus_req_s           bus_req;
    plic_bus_rsp_s           bus_rsp;
    logic [SOURCE_COUNT-1:0] irq_src;
    logic [TARGET_COUNT-1:0] irq;

    logic [15:0]           lfsr_state;
    logic [PRIO_WIDTH-1:0] prio_tab [1:SOURCE_COUNT];

    plic_top #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT),
        .PRIO_WIDTH   (PRIO_WIDTH)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .irq_src_i (irq_src),
        .irq_o     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Checking and random helpers
    // ----------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_irq(input string name, input logic [TARGET_COUNT-1:0] got,
                             input logic [TARGET_COUNT-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [XLEN-1:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // Two passes find the top priority first and then the lowest source holding it
    function automatic logic [XLEN-1:0] model_claim(input logic [SOURCE_COUNT:1] eligible,
                                                    input logic [PRIO_WIDTH-1:0] threshold);
        logic [PRIO_WIDTH-1:0] max_prio;
        logic [XLEN-1:0]       winner;
        max_prio = '0;
        winner   = '0;
        for (int s = 1; s <= SOURCE_COUNT; s++) begin
            if (eligible[s] && prio_tab[s] > max_prio) begin
                max_prio = prio_tab[s];
            end
        end
        if (max_prio > threshold) begin
            for (int s = SOURCE_COUNT; s >= 1; s--) begin
                if (eligible[s] && prio_tab[s] == max_prio) begin
                    winner = XLEN'(s);
                end
            end
        end
        return winner;
    endfunction

    // ----------------------------------------
    // Bus access
    // ----------------------------------------
    function automatic logic [XLEN-1:0] prio_reg(input int s);
        return XLEN'(`PLIC_PRIO_BASE + 4 * s);
    endfunction

    function automatic logic [XLEN-1:0] ie_reg(input int t);
        return XLEN'(`PLIC_IE_BASE + t * `PLIC_IE_STRIDE);
    endfunction

    function automatic logic [XLEN-1:0] th_reg(input int t);
        return XLEN'(`PLIC_TH_BASE + t * `PLIC_TH_STRIDE);
    endfunction

    function automatic logic [XLEN-1:0] claim_reg(input int t);
        return th_reg(t) + XLEN'(`PLIC_CLAIM_OFS);
    endfunction

    // Entered 2 ns after a rising edge and returns at the same point
    task automatic bus_access(input logic w_en, input logic [XLEN-1:0] addr,
                              input logic [XLEN-1:0] w_data, output logic [XLEN-1:0] r_data);
        int cycles;
        bus_req = '{req: 1'b1, w_en: w_en, addr: addr, w_data: w_data};
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_failure("Bus access got no acknowledge in time");
            end
        end while (!bus_rsp.ack);
        r_data = bus_rsp.r_data;
        @(posedge clk);
        #2;
        bus_req.req = 1'b0;
    endtask

    task automatic bus_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        logic [XLEN-1:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
        bus_access(1'b0, addr, '0, data);
    endtask

    task automatic set_prio(input int s, input logic [PRIO_WIDTH-1:0] val);
        bus_write(prio_reg(s), XLEN'(val));
        prio_tab[s] = val;
    endtask

    task automatic wait_pending(input logic [XLEN-1:0] exp);
        logic [XLEN-1:0] val;
        int              tries;
        tries = 0;
        bus_read(PENDING_ADDR, val);
        while (val !== exp) begin
            tries++;
            if (tries > TIMEOUT) begin
                stop_with_failure("Pending bits never reached the expected pattern");
            end
            bus_read(PENDING_ADDR, val);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_reset_state();
        logic [XLEN-1:0] got;
        check_irq("irq_o", irq, '0);
        for (int s = 1; s <= SOURCE_COUNT; s++) begin
            bus_read(prio_reg(s), got);
            check_data("priority", got, '0);
        end
        bus_read(PENDING_ADDR, got);
        check_data("pending", got, '0);
        for (int t = 0; t < TARGET_COUNT; t++) begin
            bus_read(ie_reg(t), got);
            check_data("enable", got, '0);
            bus_read(th_reg(t), got);
            check_data("threshold", got, '0);
            bus_read(claim_reg(t), got);
            check_data("claim", got, '0);
        end
    endtask

    task automatic test_readback();
        logic [XLEN-1:0] val;
        logic [XLEN-1:0] got;
        for (int s = 1; s <= SOURCE_COUNT; s++) begin
            draw_bits(XLEN, val);
            bus_write(prio_reg(s), val);
            bus_read(prio_reg(s), got);
            check_data("priority", got, XLEN'(val[PRIO_WIDTH-1:0]));
            prio_tab[s] = val[PRIO_WIDTH-1:0];
        end
        for (int t = 0; t < TARGET_COUNT; t++) begin
            draw_bits(XLEN, val);
            bus_write(ie_reg(t), val);
            bus_read(ie_reg(t), got);
            check_data("enable", got, val & ALL_SRC);
            draw_bits(XLEN, val);
            bus_write(th_reg(t), val);
            bus_read(th_reg(t), got);
            check_data("threshold", got, XLEN'(val[PRIO_WIDTH-1:0]));
        end
        bus_write(prio_reg(0), '1);
        bus_read(prio_reg(0), got);
        check_data("priority 0", got, '0);
        bus_write(PENDING_ADDR, '1);
        bus_read(PENDING_ADDR, got);
        check_data("pending", got, '0);
        // Neither write may land in a priority register
        for (int s = 1; s <= SOURCE_COUNT; s++) begin
            bus_read(prio_reg(s), got);
            check_data("priority", got, XLEN'(prio_tab[s]));
        end
    endtask

    task automatic test_pending();
        logic [XLEN-1:0] got;
        logic [XLEN-1:0] exp;
        for (int s = 1; s <= SOURCE_COUNT; s++) begin
            set_prio(s, '0);
        end
        for (int t = 0; t < TARGET_COUNT; t++) begin
            bus_write(ie_reg(t), ALL_SRC);
            bus_write(th_reg(t), '0);
        end
        exp = '0;
        for (int s = 1; s <= SOURCE_COUNT; s++) begin
            irq_src[s-1] = 1'b1;
            // This read samples on the same edge that latches the line
            bus_read(PENDING_ADDR, got);
            check_data("pending", got, exp);
            exp[s] = 1'b1;
            bus_read(PENDING_ADDR, got);
            check_data("pending", got, exp);
            check_irq("irq_o", irq, '0);
        end
    endtask

    task automatic test_arbitration();
        logic [XLEN-1:0]       val;
        logic [XLEN-1:0]       got;
        logic [XLEN-1:0]       exp0;
        logic [XLEN-1:0]       exp1;
        logic [PRIO_WIDTH-1:0] th1;
        logic [SOURCE_COUNT:1] elig;
        for (int round = 0; round < 6; round++) begin
            for (int s = 1; s <= SOURCE_COUNT; s++) begin
                draw_bits(PRIO_WIDTH, val);
                set_prio(s, val[PRIO_WIDTH-1:0]);
            end
            draw_bits(PRIO_WIDTH, val);
            th1 = val[PRIO_WIDTH-1:0];
            bus_write(th_reg(1), XLEN'(th1));
            elig = '1;
            exp0 = model_claim(elig, '0);
            exp1 = model_claim(elig, th1);
            check_irq("irq_o", irq, {exp1 != '0, exp0 != '0});
            bus_read(claim_reg(0), got);
            check_data("claim[0]", got, exp0);
            // A claimed source is in flight and out of the running
            for (int s = 1; s <= SOURCE_COUNT; s++) begin
                if (XLEN'(s) == exp0) begin
                    elig[s] = 1'b0;
                end
            end
            exp1 = model_claim(elig, th1);
            bus_read(claim_reg(1), got);
            check_data("claim[1]", got, exp1);
            bus_write(claim_reg(0), exp0);
            bus_write(claim_reg(1), exp1);
            wait_pending(ALL_SRC);
        end
        bus_write(th_reg(1), '0);
    endtask

    task automatic test_claim_complete();
        logic [XLEN-1:0] got;
        logic [XLEN-1:0] exp;
        for (int s = 1; s <= SOURCE_COUNT; s++) begin
            set_prio(s, (s == 2) ? PRIO_WIDTH'(5) : '0);
        end
        check_irq("irq_o", irq, 2'b11);
        bus_read(claim_reg(0), got);
        check_data("claim[0]", got, XLEN'(2));
        exp    = ALL_SRC;
        exp[2] = 1'b0;
        bus_read(PENDING_ADDR, got);
        check_data("pending", got, exp);
        bus_read(PENDING_ADDR, got);
        check_data("pending", got, exp);
        check_irq("irq_o", irq, 2'b00);
        bus_read(claim_reg(1), got);
        check_data("claim[1]", got, '0);
        bus_write(claim_reg(0), XLEN'(2));
        wait_pending(ALL_SRC);
        check_irq("irq_o", irq, 2'b11);
        bus_read(claim_reg(1), got);
        check_data("claim[1]", got, XLEN'(2));
        check_irq("irq_o", irq, 2'b00);
        bus_write(claim_reg(1), XLEN'(2));
        wait_pending(ALL_SRC);
    endtask

    task automatic test_masking();
        logic [XLEN-1:0] got;
        logic [XLEN-1:0] mask;
        set_prio(1, PRIO_WIDTH'(3));
        set_prio(2, '0);
        set_prio(3, PRIO_WIDTH'(6));
        set_prio(4, '0);
        check_irq("irq_o", irq, 2'b11);
        // Equal to the top priority is not enough
        bus_write(th_reg(0), XLEN'(6));
        check_irq("irq_o", irq, 2'b10);
        bus_write(th_reg(0), XLEN'(2));
        check_irq("irq_o", irq, 2'b11);
        mask    = ALL_SRC;
        mask[3] = 1'b0;
        bus_write(ie_reg(1), mask);
        bus_read(claim_reg(1), got);
        check_data("claim[1]", got, XLEN'(1));
        check_irq("irq_o", irq, 2'b01);
        bus_read(claim_reg(0), got);
        check_data("claim[0]", got, XLEN'(3));
        check_irq("irq_o", irq, 2'b00);
        bus_write(claim_reg(1), XLEN'(1));
        bus_write(claim_reg(0), XLEN'(3));
        wait_pending(ALL_SRC);
    endtask

    initial begin
        rst_n      = 1'b0;
        bus_req    = '0;
        irq_src    = '0;
        lfsr_state = 16'd16018;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_readback();
        test_pending();
        test_arbitration();
        test_claim_complete();
        test_masking();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- plic.f
+incdir+include
rtl/plic_pkg.sv
rtl/plic_bus_if.sv
rtl/plic_claim_if.sv
rtl/plic_regs.sv
rtl/plic_gateway.sv
rtl/plic_target.sv
rtl/plic_top.sv
test/plic_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := plic_tb
FILELIST  := plic.f
FLAGS     := --binary --timing -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation passed

SOURCES := $(wildcard rtl/*.sv include/*.svh test/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
